//--- hdl/daq_pkg.sv
package daq_pkg;

    // command layout
    localparam int unsigned CMD_LEN = 12;
    localparam logic [7:0] CMD_HDR0 = 8'h55;
    localparam logic [7:0] CMD_HDR1 = 8'hAA;

    // first byte of every outgoing frame
    localparam logic [7:0] FRAME_HDR = 8'h5A;

    // config bank, command bytes 2..10 with byte 2 in the top bits
    typedef struct packed {
        logic [7:0] kind_dev;
        logic [7:0] info_sr;
        logic [7:0] cmd_filt;
        logic [7:0] cmd_mix0;
        logic [7:0] cmd_mix1;
        logic [7:0] cmd_reg4;
        logic [7:0] cmd_reg5;
        logic [7:0] cmd_reg6;
        logic [7:0] cmd_reg7;
    } cfg_bank_t;

    // command parser
    typedef enum logic [2:0] {
        PARSE_IDLE,
        PARSE_HEADER,
        PARSE_BODY,
        PARSE_CHECK,
        PARSE_DRAIN,
        PARSE_DONE
    } parse_state_e;

    // frame packer
    typedef enum logic [2:0] {
        PACK_IDLE,
        PACK_HDR,
        PACK_KIND,
        PACK_SEQ,
        PACK_DATA,
        PACK_DONE
    } pack_state_e;

    // control sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_PARSE,
        SEQ_PACK
    } seq_state_e;

endpackage

//--- hdl/byte_fifo.sv
module byte_fifo #(
    parameter int FIFO_AW = 5
) (
    input  logic               sys_clk,
    input  logic               arst_n,
    input  logic               wr_valid,
    input  logic [7:0]         wr_data,
    output logic               wr_ready,
    output logic               rd_valid,
    input  logic               rd_ready,
    output logic [7:0]         rd_data,
    output logic [FIFO_AW:0]   count
);

    localparam int DEPTH = 1 << FIFO_AW;
    // occupancy value when every slot holds a byte
    localparam logic [FIFO_AW:0] FULL_CNT = {1'b1, {FIFO_AW{1'b0}}};

    logic [7:0]         mem [DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic               push;
    logic               pop;

    // flags straight from occupancy
    assign wr_ready = (count != FULL_CNT);
    assign rd_valid = (count != '0);

    // oldest byte always on the read side
    assign rd_data = mem[rd_ptr];

    assign push = wr_valid & wr_ready;
    assign pop  = rd_valid & rd_ready;

    // storage array
    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap naturally at DEPTH
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // simultaneous push and pop leaves count as is
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/cmd_parser.sv
module cmd_parser (
    input  logic               sys_clk,
    input  logic               arst_n,
    input  logic               fs_parse,
    output logic               fd_parse,
    input  logic               rd_valid,
    input  logic [7:0]         rd_data,
    output logic               rd_ready,
    output logic               cmd_ok,
    output logic               cmd_err,
    output daq_pkg::cfg_bank_t cfg
);

    import daq_pkg::*;

    // byte positions inside a command
    localparam logic [3:0] LAST_BODY = 4'(CMD_LEN - 2);
    localparam logic [3:0] LAST_BYTE = 4'(CMD_LEN - 1);

    parse_state_e state;
    logic [3:0]   idx;
    logic [7:0]   sum;
    logic         good;
    cfg_bank_t    shadow;
    logic         pop;

    // pop only while a command is being walked
    assign rd_ready = (state == PARSE_HEADER) || (state == PARSE_BODY) ||
                      (state == PARSE_CHECK)  || (state == PARSE_DRAIN);
    assign pop = rd_valid & rd_ready;

    // one-cycle done with its verdict
    assign fd_parse = (state == PARSE_DONE);
    assign cmd_ok   = fd_parse & good;
    assign cmd_err  = fd_parse & ~good;

    // shadow bank, bytes shift in from the bottom
    always_ff @(posedge sys_clk) begin
        if (state == PARSE_BODY && pop) begin
            shadow <= {shadow[63:0], rd_data};
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= PARSE_IDLE;
            idx   <= '0;
            sum   <= '0;
            good  <= 1'b0;
            cfg   <= '0;
        end else begin
            case (state)
                PARSE_IDLE: begin
                    idx  <= '0;
                    sum  <= '0;
                    good <= 1'b0;
                    if (fs_parse) begin
                        state <= PARSE_HEADER;
                    end
                end
                PARSE_HEADER: begin
                    if (pop) begin
                        idx <= idx + 1'b1;
                        // bad header byte, skip what is left
                        if (rd_data != ((idx == '0) ? CMD_HDR0 : CMD_HDR1)) begin
                            state <= PARSE_DRAIN;
                        end else if (idx != '0) begin
                            state <= PARSE_BODY;
                        end
                    end
                end
                PARSE_BODY: begin
                    if (pop) begin
                        idx <= idx + 1'b1;
                        sum <= sum + rd_data;
                        if (idx == LAST_BODY) begin
                            state <= PARSE_CHECK;
                        end
                    end
                end
                PARSE_CHECK: begin
                    if (pop) begin
                        // commit here so cfg is current during the done pulse
                        if (rd_data == sum) begin
                            good <= 1'b1;
                            cfg  <= shadow;
                        end
                        state <= PARSE_DONE;
                    end
                end
                PARSE_DRAIN: begin
                    if (pop) begin
                        idx <= idx + 1'b1;
                        if (idx == LAST_BYTE) begin
                            state <= PARSE_DONE;
                        end
                    end
                end
                PARSE_DONE: begin
                    state <= PARSE_IDLE;
                end
                default: begin
                    state <= PARSE_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/frame_packer.sv
module frame_packer #(
    parameter int PAYLOAD_LEN = 8
) (
    input  logic       sys_clk,
    input  logic       arst_n,
    input  logic       fs_pack,
    output logic       fd_pack,
    input  logic [7:0] kind_dev,
    input  logic       rd_valid,
    input  logic [7:0] rd_data,
    output logic       rd_ready,
    output logic       tx_valid,
    input  logic       tx_ready,
    output logic [7:0] tx_data,
    output logic       tx_last
);

    import daq_pkg::*;

    localparam int CNT_W = (PAYLOAD_LEN > 1) ? $clog2(PAYLOAD_LEN) : 1;
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(PAYLOAD_LEN - 1);

    pack_state_e      state;
    logic [CNT_W-1:0] data_cnt;
    logic [7:0]       seq_num;
    logic [7:0]       kind_q;
    logic             xfer;

    // payload bytes go straight from fifo to tx
    assign rd_ready = (state == PACK_DATA) & tx_ready;

    always_comb begin
        case (state)
            PACK_HDR: begin
                tx_valid = 1'b1;
                tx_data  = FRAME_HDR;
            end
            PACK_KIND: begin
                tx_valid = 1'b1;
                tx_data  = kind_q;
            end
            PACK_SEQ: begin
                tx_valid = 1'b1;
                tx_data  = seq_num;
            end
            PACK_DATA: begin
                tx_valid = rd_valid;
                tx_data  = rd_data;
            end
            default: begin
                tx_valid = 1'b0;
                tx_data  = '0;
            end
        endcase
    end

    assign tx_last = (state == PACK_DATA) && (data_cnt == LAST_IDX);
    assign xfer    = tx_valid & tx_ready;
    assign fd_pack = (state == PACK_DONE);

    // kind byte frozen for the whole frame
    always_ff @(posedge sys_clk) begin
        if (state == PACK_IDLE && fs_pack) begin
            kind_q <= kind_dev;
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= PACK_IDLE;
            data_cnt <= '0;
            seq_num  <= '0;
        end else begin
            case (state)
                PACK_IDLE: begin
                    data_cnt <= '0;
                    if (fs_pack) begin
                        state <= PACK_HDR;
                    end
                end
                PACK_HDR: begin
                    if (xfer) begin
                        state <= PACK_KIND;
                    end
                end
                PACK_KIND: begin
                    if (xfer) begin
                        state <= PACK_SEQ;
                    end
                end
                PACK_SEQ: begin
                    if (xfer) begin
                        state <= PACK_DATA;
                    end
                end
                PACK_DATA: begin
                    if (xfer) begin
                        data_cnt <= data_cnt + 1'b1;
                        if (tx_last) begin
                            state <= PACK_DONE;
                        end
                    end
                end
                PACK_DONE: begin
                    // next frame number
                    seq_num <= seq_num + 1'b1;
                    state   <= PACK_IDLE;
                end
                default: begin
                    state <= PACK_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/ctrl_seq.sv
module ctrl_seq #(
    parameter int FIFO_AW     = 5,
    parameter int PAYLOAD_LEN = 8
) (
    input  logic             sys_clk,
    input  logic             arst_n,
    input  logic [FIFO_AW:0] cmd_count,
    input  logic [FIFO_AW:0] dat_count,
    output logic             fs_parse,
    input  logic             fd_parse,
    input  logic             cmd_ok,
    input  logic [7:0]       new_kind,
    output logic             fs_pack,
    input  logic             fd_pack,
    output logic             armed
);

    import daq_pkg::*;

    // fifo levels that allow a start
    localparam logic [FIFO_AW:0] CMD_THR = (FIFO_AW + 1)'(CMD_LEN);
    localparam logic [FIFO_AW:0] DAT_THR = (FIFO_AW + 1)'(PAYLOAD_LEN);

    seq_state_e state;

    // start flags held for the whole job
    assign fs_parse = (state == SEQ_PARSE);
    assign fs_pack  = (state == SEQ_PACK);

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= SEQ_IDLE;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    // a full command wins over a ready frame
                    if (cmd_count >= CMD_THR) begin
                        state <= SEQ_PARSE;
                    end else if (armed && dat_count >= DAT_THR) begin
                        state <= SEQ_PACK;
                    end
                end
                SEQ_PARSE: begin
                    if (fd_parse) begin
                        state <= SEQ_IDLE;
                    end
                end
                SEQ_PACK: begin
                    // frame always runs to its end
                    if (fd_pack) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // kind zero in a good command disarms
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            armed <= 1'b0;
        end else if (cmd_ok) begin
            armed <= (new_kind != '0);
        end
    end

endmodule

//--- hdl/daq_top.sv
module daq_top #(
    parameter int FIFO_AW     = 5,
    parameter int PAYLOAD_LEN = 8
) (
    input  logic               sys_clk,
    input  logic               arst_n,
    input  logic               cmd_valid,
    output logic               cmd_ready,
    input  logic [7:0]         cmd_data,
    input  logic               adc_valid,
    output logic               adc_ready,
    input  logic [7:0]         adc_data,
    output logic               tx_valid,
    input  logic               tx_ready,
    output logic [7:0]         tx_data,
    output logic               tx_last,
    output daq_pkg::cfg_bank_t cfg,
    output logic               cmd_ok,
    output logic               cmd_err,
    output logic               armed
);

    // command fifo read side
    logic             cmd_rd_valid;
    logic             cmd_rd_ready;
    logic [7:0]       cmd_rd_data;
    logic [FIFO_AW:0] cmd_count;

    // data fifo read side
    logic             dat_rd_valid;
    logic             dat_rd_ready;
    logic [7:0]       dat_rd_data;
    logic [FIFO_AW:0] dat_count;

    // start and done flags
    logic fs_parse;
    logic fd_parse;
    logic fs_pack;
    logic fd_pack;

    byte_fifo #(
        .FIFO_AW (FIFO_AW)
    ) u_cmd_fifo (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .wr_valid (cmd_valid),
        .wr_data  (cmd_data),
        .wr_ready (cmd_ready),
        .rd_valid (cmd_rd_valid),
        .rd_ready (cmd_rd_ready),
        .rd_data  (cmd_rd_data),
        .count    (cmd_count)
    );

    // samples land here armed or not
    byte_fifo #(
        .FIFO_AW (FIFO_AW)
    ) u_dat_fifo (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .wr_valid (adc_valid),
        .wr_data  (adc_data),
        .wr_ready (adc_ready),
        .rd_valid (dat_rd_valid),
        .rd_ready (dat_rd_ready),
        .rd_data  (dat_rd_data),
        .count    (dat_count)
    );

    cmd_parser u_cmd_parser (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .fs_parse (fs_parse),
        .fd_parse (fd_parse),
        .rd_valid (cmd_rd_valid),
        .rd_data  (cmd_rd_data),
        .rd_ready (cmd_rd_ready),
        .cmd_ok   (cmd_ok),
        .cmd_err  (cmd_err),
        .cfg      (cfg)
    );

    frame_packer #(
        .PAYLOAD_LEN (PAYLOAD_LEN)
    ) u_frame_packer (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .fs_pack  (fs_pack),
        .fd_pack  (fd_pack),
        .kind_dev (cfg.kind_dev),
        .rd_valid (dat_rd_valid),
        .rd_data  (dat_rd_data),
        .rd_ready (dat_rd_ready),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_data  (tx_data),
        .tx_last  (tx_last)
    );

    // kind byte from the bank decides arming
    ctrl_seq #(
        .FIFO_AW     (FIFO_AW),
        .PAYLOAD_LEN (PAYLOAD_LEN)
    ) u_ctrl_seq (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .cmd_count (cmd_count),
        .dat_count (dat_count),
        .fs_parse  (fs_parse),
        .fd_parse  (fd_parse),
        .cmd_ok    (cmd_ok),
        .new_kind  (cfg.kind_dev),
        .fs_pack   (fs_pack),
        .fd_pack   (fd_pack),
        .armed     (armed)
    );

endmodule

//--- test/tb_daq.sv
module tb_daq;

    localparam int PAYLOAD_LEN = 8;

    // command kinds built by send_cmd
    localparam int MODE_GOOD     = 0;
    localparam int MODE_BAD_SUM  = 1;
    localparam int MODE_BAD_HDR0 = 2;
    localparam int MODE_BAD_HDR1 = 3;
    localparam int MODE_KIND0    = 4;

    // stimulus volume, sets the cycle limit
    localparam int N_ADC_T1    = 20;
    localparam int N_ADC_T4    = 64;
    localparam int N_ADC_T5    = 96;
    localparam int N_ADC_T6    = 16;
    localparam int N_ADC_T7    = PAYLOAD_LEN;
    localparam int N_CMDS      = 8;
    localparam int TOTAL_BYTES = 12 * N_CMDS + N_ADC_T1 + N_ADC_T4 + N_ADC_T5 + N_ADC_T6 +
                                 N_ADC_T7;
    localparam int CYCLE_LIMIT = 20 * TOTAL_BYTES + 2000;

    logic        sys_clk;
    logic        arst_n;
    logic        cmd_valid;
    logic        cmd_ready;
    logic [7:0]  cmd_data;
    logic        adc_valid;
    logic        adc_ready;
    logic [7:0]  adc_data;
    logic        tx_valid;
    logic        tx_ready;
    logic [7:0]  tx_data;
    logic        tx_last;
    logic [71:0] cfg;
    logic        cmd_ok;
    logic        cmd_err;
    logic        armed;

    integer      seed = 50;
    int          cycles;
    int          err_count;
    int          tests_ok;
    int          tests_bad;
    bit          gaps_on;
    bit          bp_on;

    // reference model state
    logic [72:0] exp_q[$];
    logic [7:0]  adc_q[$];
    logic [72:0] exp_item;
    logic [71:0] model_bank;
    logic [71:0] last_bank;
    logic        model_armed;
    logic [7:0]  model_seq;
    logic [7:0]  frame_kind;
    logic [7:0]  sample;
    int          frame_pos;
    int          frames_seen;
    int          ok_seen;
    int          bad_seen;

    daq_top u_dut (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_data  (cmd_data),
        .adc_valid (adc_valid),
        .adc_ready (adc_ready),
        .adc_data  (adc_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .tx_data   (tx_data),
        .tx_last   (tx_last),
        .cfg       (cfg),
        .cmd_ok    (cmd_ok),
        .cmd_err   (cmd_err),
        .armed     (armed)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    function automatic logic [7:0] rand_byte();
        return 8'($random(seed));
    endfunction

    function automatic int rand_gap();
        return $random(seed) & 3;
    endfunction

    task automatic check_val(input string name, input logic [71:0] actual,
                             input logic [71:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s at %0t: got %0h expected %0h", name, $time, actual, expected);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (err_count == err_before) begin
            $display("%s ok", name);
            tests_ok++;
        end else begin
            $display("%s %0d errors", name, err_count - err_before);
            tests_bad++;
        end
    endtask

    // builds one command, queues its outcome, then pushes its 12 bytes
    task automatic send_cmd(input int mode);
        logic [7:0]  b [12];
        logic [7:0]  sum;
        logic [71:0] bank;
        int          i;
        int          gap;
        b[0] = 8'h55;
        b[1] = 8'hAA;
        sum  = '0;
        bank = '0;
        for (i = 2; i <= 10; i++) begin
            b[i] = rand_byte();
        end
        // kind zero only where a disarm is wanted
        if (mode == MODE_KIND0) begin
            b[2] = 8'h00;
        end else if (b[2] == 8'h00) begin
            b[2] = 8'h01;
        end
        for (i = 2; i <= 10; i++) begin
            sum  = sum + b[i];
            bank = {bank[63:0], b[i]};
        end
        b[11] = sum;
        case (mode)
            MODE_BAD_SUM:  b[11] = sum + 8'h01;
            MODE_BAD_HDR0: b[0] = 8'h54;
            MODE_BAD_HDR1: b[1] = 8'h2A;
            default:       b[11] = sum;
        endcase
        if (mode == MODE_GOOD || mode == MODE_KIND0) begin
            exp_q.push_back({1'b1, bank});
            last_bank = bank;
        end else begin
            exp_q.push_back({1'b0, bank});
        end
        for (i = 0; i < 12; i++) begin
            cmd_valid = 1'b0;
            gap = gaps_on ? rand_gap() : 0;
            if (gap > 0) begin
                repeat (gap) @(posedge sys_clk);
                #1;
            end
            cmd_valid = 1'b1;
            cmd_data  = b[i];
            // ready is settled by the falling edge
            @(negedge sys_clk);
            while (!cmd_ready) @(negedge sys_clk);
            @(posedge sys_clk);
            #1;
        end
        cmd_valid = 1'b0;
    endtask

    task automatic send_adc(input int n);
        int i;
        int gap;
        for (i = 0; i < n; i++) begin
            adc_valid = 1'b0;
            gap = gaps_on ? rand_gap() : 0;
            if (gap > 0) begin
                repeat (gap) @(posedge sys_clk);
                #1;
            end
            adc_valid = 1'b1;
            adc_data  = rand_byte();
            @(negedge sys_clk);
            while (!adc_ready) @(negedge sys_clk);
            @(posedge sys_clk);
            #1;
        end
        adc_valid = 1'b0;
    endtask

    // no outcome pending, no frame open, optionally fewer than a frame of samples
    task automatic wait_idle(input bit need_drain);
        do begin
            @(posedge sys_clk);
            #1;
        end while (exp_q.size() != 0 || frame_pos != 0 ||
                   (need_drain && adc_q.size() >= PAYLOAD_LEN));
        repeat (2) @(posedge sys_clk);
        #1;
    endtask

    // tx back-pressure
    initial begin
        tx_ready = 1'b1;
        forever begin
            @(posedge sys_clk);
            #1;
            tx_ready = bp_on ? ((rand_gap() != 0) ? 1'b1 : 1'b0) : 1'b1;
        end
    end

    // monitor at the falling edge, where every output has settled
    always @(negedge sys_clk) begin
        if (arst_n) begin
            if (adc_valid && adc_ready) begin
                adc_q.push_back(adc_data);
            end
            // armed follows cmd_ok by one cycle
            check_val("armed", 72'(armed), 72'(model_armed));
            if (cmd_ok || cmd_err) begin
                // verdicts as the dut reported them
                if (cmd_ok) begin
                    ok_seen++;
                end
                if (cmd_err) begin
                    bad_seen++;
                end
                if (exp_q.size() == 0) begin
                    $display("error at %0t: command outcome with no command pending", $time);
                    err_count++;
                end else begin
                    exp_item = exp_q.pop_front();
                    check_val("cmd_ok", 72'(cmd_ok), 72'(exp_item[72]));
                    check_val("cmd_err", 72'(cmd_err), 72'(!exp_item[72]));
                    if (exp_item[72]) begin
                        model_bank  = exp_item[71:0];
                        model_armed = (exp_item[71:64] != 8'h00);
                    end
                end
            end
            check_val("cfg", cfg, model_bank);
            if (tx_valid && frame_pos == 0 && !model_armed) begin
                $display("error at %0t: frame started while the system was disarmed", $time);
                err_count++;
            end
            if (tx_valid && tx_ready) begin
                if (frame_pos == 0) begin
                    frame_kind = model_bank[71:64];
                    check_val("tx_data", 72'(tx_data), 72'(8'h5A));
                end else if (frame_pos == 1) begin
                    check_val("tx_data", 72'(tx_data), 72'(frame_kind));
                end else if (frame_pos == 2) begin
                    check_val("tx_data", 72'(tx_data), 72'(model_seq));
                end else if (adc_q.size() == 0) begin
                    $display("error at %0t: payload byte sent with no sample left", $time);
                    err_count++;
                end else begin
                    sample = adc_q.pop_front();
                    check_val("tx_data", 72'(tx_data), 72'(sample));
                end
                check_val("tx_last", 72'(tx_last), 72'(frame_pos == PAYLOAD_LEN + 2));
                if (frame_pos == PAYLOAD_LEN + 2) begin
                    frame_pos = 0;
                    model_seq = model_seq + 8'h01;
                    frames_seen++;
                end else begin
                    frame_pos++;
                end
            end
        end
    end

    // hard stop on a hung run
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge sys_clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    initial begin
        int err_before;
        int q_before;
        int frames_before;
        int ok_before;
        int bad_before;
        arst_n      = 1'b0;
        cmd_valid   = 1'b0;
        cmd_data    = '0;
        adc_valid   = 1'b0;
        adc_data    = '0;
        gaps_on     = 1'b0;
        bp_on       = 1'b0;
        model_bank  = '0;
        last_bank   = '0;
        model_armed = 1'b0;
        model_seq   = '0;
        frame_pos   = 0;
        repeat (10) @(posedge sys_clk);
        #1;
        arst_n = 1'b1;

        // samples before any command, nothing may go out
        err_before = err_count;
        check_val("cfg", cfg, 72'h0);
        check_val("armed", 72'(armed), 72'h0);
        check_val("cmd_ready", 72'(cmd_ready), 72'h1);
        check_val("adc_ready", 72'(adc_ready), 72'h1);
        send_adc(N_ADC_T1);
        repeat (100) @(posedge sys_clk);
        #1;
        check_val("frame count", 72'(frames_seen), 72'h0);
        report_test("reset and idle", err_before);

        // first good command arms, stored samples go out first
        err_before = err_count;
        send_cmd(MODE_GOOD);
        wait_idle(1'b1);
        check_val("cfg", cfg, last_bank);
        check_val("armed", 72'(armed), 72'h1);
        report_test("good command arms", err_before);

        // bad commands must each take exactly 12 bytes
        err_before = err_count;
        ok_before  = ok_seen;
        bad_before = bad_seen;
        send_cmd(MODE_BAD_SUM);
        send_cmd(MODE_BAD_HDR0);
        send_cmd(MODE_BAD_HDR1);
        wait_idle(1'b1);
        check_val("cfg", cfg, last_bank);
        send_cmd(MODE_GOOD);
        wait_idle(1'b1);
        check_val("cfg", cfg, last_bank);
        check_val("cmd_err count", 72'(bad_seen - bad_before), 72'd3);
        check_val("cmd_ok count", 72'(ok_seen - ok_before), 72'd1);
        report_test("bad commands rejected", err_before);

        // steady stream, no back-pressure
        err_before    = err_count;
        q_before      = adc_q.size();
        frames_before = frames_seen;
        send_adc(N_ADC_T4);
        wait_idle(1'b1);
        check_val("payload bytes", 72'((frames_seen - frames_before) * PAYLOAD_LEN),
                  72'(q_before + N_ADC_T4 - adc_q.size()));
        report_test("streaming frames", err_before);

        // gaps on both inputs, random tx_ready, commands in between
        err_before    = err_count;
        gaps_on       = 1'b1;
        bp_on         = 1'b1;
        q_before      = adc_q.size();
        frames_before = frames_seen;
        fork
            send_adc(N_ADC_T5);
            begin
                send_cmd(MODE_GOOD);
                repeat (4 + rand_gap() * 8) @(posedge sys_clk);
                #1;
                send_cmd(MODE_GOOD);
            end
        join
        wait_idle(1'b1);
        check_val("payload bytes", 72'((frames_seen - frames_before) * PAYLOAD_LEN),
                  72'(q_before + N_ADC_T5 - adc_q.size()));
        report_test("back-pressure and gaps", err_before);

        // kind zero disarms, open frame still finishes
        err_before = err_count;
        fork
            send_adc(N_ADC_T6);
            begin
                repeat (4 + rand_gap() * 4) @(posedge sys_clk);
                #1;
                send_cmd(MODE_KIND0);
            end
        join
        wait_idle(1'b0);
        frames_before = frames_seen;
        // a whole frame of fresh samples, still nothing may go out
        send_adc(N_ADC_T7);
        repeat (200) @(posedge sys_clk);
        #1;
        check_val("armed", 72'(armed), 72'h0);
        check_val("frame count", 72'(frames_seen), 72'(frames_before));
        report_test("disarm stops frames", err_before);

        $display("tests: %0d ok, %0d with errors, %0d checks failed, %0d frames seen",
                 tests_ok, tests_bad, err_count, frames_seen);
        if (tests_bad == 0 && err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
hdl/daq_pkg.sv
hdl/byte_fifo.sv
hdl/cmd_parser.sv
hdl/frame_packer.sv
hdl/ctrl_seq.sv
hdl/daq_top.sv
test/tb_daq.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_daq -f verilog.f -o tb_daq_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_daq_sim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1
